// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = tb_pll_reconfig_top
FILELIST = pll_reconfig_top.f
OBJ_DIR = obj_dir
PASS_MSG = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== clkout_reg_encoder.sv ====
module clkout_reg_encoder (
	// Low selects CLKREG1, high selects CLKREG2
	input logic reg2_sel,

	// Host command fields
	input reconfig_pkg::out_idx_t reconfig_output_idx,
	input reconfig_pkg::out_div_t reconfig_output_div,
	input reconfig_pkg::out_phase_t reconfig_output_phase,

	// Register write for the sequencer
	output drp_pkg::drp_addr_t enc_addr,
	output drp_pkg::drp_data_t enc_wdata,
	output drp_pkg::drp_data_t enc_wmask
);

	drp_pkg::drp_addr_t base_addr;
	drp_pkg::drp_data_t reg2_mask;
	drp_pkg::drp_data_t reg1_data;
	drp_pkg::drp_data_t reg2_data;
	logic [5:0] half_div;
	logic [5:0] low_time;
	logic idx_legal;

	//////////////////////////////////////////////////
	// Per-output address and reserved bits

	always_comb begin
		idx_legal = (int'(reconfig_output_idx) < reconfig_pkg::NUM_OUTPUTS);
		case (reconfig_output_idx)
			3'd0: base_addr = drp_pkg::REG_CLKOUT0_CLKREG1;
			3'd1: base_addr = drp_pkg::REG_CLKOUT1_CLKREG1;
			3'd2: base_addr = drp_pkg::REG_CLKOUT2_CLKREG1;
			3'd3: base_addr = drp_pkg::REG_CLKOUT3_CLKREG1;
			3'd4: base_addr = drp_pkg::REG_CLKOUT4_CLKREG1;
			3'd5: base_addr = drp_pkg::REG_CLKOUT5_CLKREG1;
			default: base_addr = drp_pkg::REG_CLKOUT0_CLKREG1;
		endcase

		// CLKREG2 layout differs on outputs 0 and 5
		case (reconfig_output_idx)
			3'd0: reg2_mask = drp_pkg::MASK_CLKREG2_OUT0;
			3'd5: reg2_mask = drp_pkg::MASK_CLKREG2_OUT5;
			default: reg2_mask = drp_pkg::MASK_CLKREG2_MID;
		endcase
	end

	//////////////////////////////////////////////////
	// Register contents

	// High time is half the divisor, low time gets the odd cycle
	assign half_div = reconfig_output_div[6:1];
	assign low_time = half_div + {5'd0, reconfig_output_div[0]};

	// CLKREG1: fine phase, reserved bit, high time, low time
	assign reg1_data = {reconfig_output_phase[2:0], 1'b0, half_div, low_time};

	// CLKREG2: edge flip for odd divisors, bypass for divide by 1, coarse phase
	assign reg2_data = {
		8'd0,
		reconfig_output_div[0],
		(reconfig_output_div == 8'd1),
		reconfig_output_phase[8:3]
	};

	assign enc_addr = base_addr + drp_pkg::drp_addr_t'(reg2_sel);
	assign enc_wdata = reg2_sel ? reg2_data : reg1_data;

	// Illegal index turns into a write to output 0 that keeps every bit
	always_comb begin
		if (!idx_legal)
			enc_wmask = 16'hffff;
		else if (reg2_sel)
			enc_wmask = reg2_mask;
		else
			enc_wmask = drp_pkg::MASK_CLKREG1;
	end

endmodule

// ==== drp_pkg.sv ====
package drp_pkg;

	//////////////////////////////////////////////////
	// DRP bus

	// Address and data words of the dynamic reconfiguration port
	typedef logic [6:0] drp_addr_t;
	typedef logic [15:0] drp_data_t;

	//////////////////////////////////////////////////
	// Clock manager register map

	// Power control for all sections
	localparam drp_addr_t REG_POWER_CONFIG = 7'h28;

	// First clock register of each output
	// The second one of an output sits at the next address
	localparam drp_addr_t REG_CLKOUT0_CLKREG1 = 7'h08;
	localparam drp_addr_t REG_CLKOUT1_CLKREG1 = 7'h0a;
	localparam drp_addr_t REG_CLKOUT2_CLKREG1 = 7'h0c;
	localparam drp_addr_t REG_CLKOUT3_CLKREG1 = 7'h0e;
	localparam drp_addr_t REG_CLKOUT4_CLKREG1 = 7'h10;
	localparam drp_addr_t REG_CLKOUT5_CLKREG1 = 7'h06;

	// Reserved bits, kept from the old register value on a write
	localparam drp_data_t MASK_CLKREG1 = 16'h1000;
	localparam drp_data_t MASK_CLKREG2_OUT0 = 16'h8000;
	// Outputs 1 to 4 share one layout
	localparam drp_data_t MASK_CLKREG2_MID = 16'hfc00;
	localparam drp_data_t MASK_CLKREG2_OUT5 = 16'hc000;

	// Every power bit set
	localparam drp_data_t POWER_ALL_ON = 16'hffff;

	//////////////////////////////////////////////////
	// Read-modify-write engine

	typedef enum logic [1:0] {
		idle,
		read,
		write
	} drp_state_t;

endpackage

// ==== drp_rmw.sv ====
module drp_rmw (
	input logic reconfig_clk,
	input logic reset,

	// Register write request from the sequencer
	input logic reg_wr,
	input drp_pkg::drp_addr_t reg_addr,
	input drp_pkg::drp_data_t reg_wdata,
	input drp_pkg::drp_data_t reg_wmask,
	output logic reg_wr_done,

	// DRP master side
	output logic drp_en,
	output logic drp_we,
	output drp_pkg::drp_addr_t drp_daddr,
	output drp_pkg::drp_data_t drp_din,
	input drp_pkg::drp_data_t drp_dout,
	input logic drp_ready
);

	drp_pkg::drp_state_t state;
	drp_pkg::drp_data_t merged;

	// Masked bits come from the register, the rest from the request
	assign merged = (drp_dout & reg_wmask) | (reg_wdata & ~reg_wmask);

	always_ff @(posedge reconfig_clk) begin
		// Strobes and address only live for the cycle they are issued
		drp_en <= 1'b0;
		drp_we <= 1'b0;
		drp_daddr <= '0;
		reg_wr_done <= 1'b0;

		if (reset) begin
			state <= drp_pkg::idle;
		end else begin
			case (state)
				// New request, read the target register first
				drp_pkg::idle: begin
					if (reg_wr) begin
						drp_en <= 1'b1;
						drp_daddr <= reg_addr;
						state <= drp_pkg::read;
					end
				end

				// Old value is back, write the merged word to the same address
				drp_pkg::read: begin
					if (drp_ready) begin
						drp_en <= 1'b1;
						drp_we <= 1'b1;
						drp_daddr <= reg_addr;
						drp_din <= merged;
						state <= drp_pkg::write;
					end
				end

				// Write acknowledged
				drp_pkg::write: begin
					if (drp_ready) begin
						reg_wr_done <= 1'b1;
						state <= drp_pkg::idle;
					end
				end

				default: begin
					state <= drp_pkg::idle;
				end
			endcase
		end
	end

endmodule

// ==== pll_reconfig_fsm.sv ====
module pll_reconfig_fsm (
	input logic reconfig_clk,
	input logic reset,

	// Host control
	input logic pll_reset_req,
	input logic reconfig_start,
	input logic reconfig_finish,
	input logic reconfig_output_en,
	output logic busy,
	output logic reconfig_cmd_done,
	output logic pll_reset,

	// Request to the DRP engine
	output logic reg_wr,
	output drp_pkg::drp_addr_t reg_addr,
	output drp_pkg::drp_data_t reg_wdata,
	output drp_pkg::drp_data_t reg_wmask,
	input logic reg_wr_done,

	// Output register encoder
	output logic reg2_sel,
	input drp_pkg::drp_addr_t enc_addr,
	input drp_pkg::drp_data_t enc_wdata,
	input drp_pkg::drp_data_t enc_wmask
);

	reconfig_pkg::reconfig_state_t state;

	// Encoder shows CLKREG2 while the first write is pending
	assign reg2_sel = (state == reconfig_pkg::outdiv_reg2);

	always_ff @(posedge reconfig_clk) begin
		if (reset) begin
			state <= reconfig_pkg::boot_power;
			busy <= 1'b1;
			pll_reset <= 1'b1;
			reg_wr <= 1'b0;
			reconfig_cmd_done <= 1'b0;
		end else begin
			reg_wr <= 1'b0;
			reconfig_cmd_done <= 1'b0;

			case (state)
				//////////////////////////////////////////////////
				// Boot

				// Turn on all power bits, nothing kept
				reconfig_pkg::boot_power: begin
					reg_wr <= 1'b1;
					reg_addr <= drp_pkg::REG_POWER_CONFIG;
					reg_wdata <= drp_pkg::POWER_ALL_ON;
					reg_wmask <= '0;
					state <= reconfig_pkg::boot_hold;
				end

				// Host strobes count once the power write is through
				reconfig_pkg::boot_hold: begin
					if (reg_wr_done)
						busy <= 1'b0;
					if (!busy) begin
						// PLL already in reset here
						if (reconfig_start)
							state <= reconfig_pkg::ready;
						else if (pll_reset_req)
							state <= reconfig_pkg::idle;
					end
				end

				//////////////////////////////////////////////////
				// Normal running

				reconfig_pkg::idle: begin
					// A reset request is one cycle long
					pll_reset <= 1'b0;
					if (reconfig_start) begin
						pll_reset <= 1'b1;
						state <= reconfig_pkg::ready;
					end else if (pll_reset_req) begin
						pll_reset <= 1'b1;
					end
				end

				//////////////////////////////////////////////////
				// Reconfiguration mode, PLL kept in reset

				reconfig_pkg::ready: begin
					if (reconfig_output_en) begin
						reg_wr <= 1'b1;
						reg_addr <= enc_addr;
						reg_wdata <= enc_wdata;
						reg_wmask <= enc_wmask;
						state <= reconfig_pkg::outdiv_reg2;
					end else if (reconfig_finish) begin
						state <= reconfig_pkg::idle;
					end
				end

				// CLKREG1 done, send CLKREG2
				reconfig_pkg::outdiv_reg2: begin
					if (reg_wr_done) begin
						reg_wr <= 1'b1;
						reg_addr <= enc_addr;
						reg_wdata <= enc_wdata;
						reg_wmask <= enc_wmask;
						state <= reconfig_pkg::cmd_finish;
					end
				end

				// Tell the host once the last write lands
				reconfig_pkg::cmd_finish: begin
					if (reg_wr_done) begin
						reconfig_cmd_done <= 1'b1;
						state <= reconfig_pkg::ready;
					end
				end

				default: begin
					state <= reconfig_pkg::boot_power;
				end
			endcase
		end
	end

endmodule

// ==== pll_reconfig_top.f ====
drp_pkg.sv
reconfig_pkg.sv
drp_rmw.sv
clkout_reg_encoder.sv
pll_reconfig_fsm.sv
pll_reconfig_top.sv
tb_drp_model.sv
tb_pll_reconfig_top.sv

// ==== pll_reconfig_top.sv ====
module pll_reconfig_top (
	input logic reconfig_clk,
	input logic reset,

	// Host side
	input logic pll_reset_req,
	input logic reconfig_start,
	input logic reconfig_finish,
	input logic reconfig_output_en,
	input reconfig_pkg::out_idx_t reconfig_output_idx,
	input reconfig_pkg::out_div_t reconfig_output_div,
	input reconfig_pkg::out_phase_t reconfig_output_phase,
	output logic busy,
	output logic reconfig_cmd_done,
	output logic pll_reset,

	// DRP of the clock manager
	output logic drp_en,
	output logic drp_we,
	output drp_pkg::drp_addr_t drp_daddr,
	output drp_pkg::drp_data_t drp_din,
	input drp_pkg::drp_data_t drp_dout,
	input logic drp_ready
);

	// Sequencer to engine
	logic reg_wr;
	logic reg_wr_done;
	drp_pkg::drp_addr_t reg_addr;
	drp_pkg::drp_data_t reg_wdata;
	drp_pkg::drp_data_t reg_wmask;

	// Encoder link
	logic reg2_sel;
	drp_pkg::drp_addr_t enc_addr;
	drp_pkg::drp_data_t enc_wdata;
	drp_pkg::drp_data_t enc_wmask;

	pll_reconfig_fsm u_fsm (
		.reconfig_clk(reconfig_clk),
		.reset(reset),
		.pll_reset_req(pll_reset_req),
		.reconfig_start(reconfig_start),
		.reconfig_finish(reconfig_finish),
		.reconfig_output_en(reconfig_output_en),
		.busy(busy),
		.reconfig_cmd_done(reconfig_cmd_done),
		.pll_reset(pll_reset),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_wmask(reg_wmask),
		.reg_wr_done(reg_wr_done),
		.reg2_sel(reg2_sel),
		.enc_addr(enc_addr),
		.enc_wdata(enc_wdata),
		.enc_wmask(enc_wmask)
	);

	clkout_reg_encoder u_encoder (
		.reg2_sel(reg2_sel),
		.reconfig_output_idx(reconfig_output_idx),
		.reconfig_output_div(reconfig_output_div),
		.reconfig_output_phase(reconfig_output_phase),
		.enc_addr(enc_addr),
		.enc_wdata(enc_wdata),
		.enc_wmask(enc_wmask)
	);

	drp_rmw u_rmw (
		.reconfig_clk(reconfig_clk),
		.reset(reset),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_wmask(reg_wmask),
		.reg_wr_done(reg_wr_done),
		.drp_en(drp_en),
		.drp_we(drp_we),
		.drp_daddr(drp_daddr),
		.drp_din(drp_din),
		.drp_dout(drp_dout),
		.drp_ready(drp_ready)
	);

endmodule

// ==== reconfig_pkg.sv ====
package reconfig_pkg;

	//////////////////////////////////////////////////
	// Output commands

	// Outputs 0 to 5 can be reprogrammed
	localparam int NUM_OUTPUTS = 6;

	// Output index, values 6 and 7 are not legal
	typedef logic [2:0] out_idx_t;

	// Divisor, bit 7 unused so legal range is 1 to 127
	typedef logic [7:0] out_div_t;

	// Phase offset in eighths of a VCO period
	typedef logic [8:0] out_phase_t;

	//////////////////////////////////////////////////
	// Reconfiguration sequencer

	typedef enum logic [2:0] {
		// Power-up write in flight
		boot_power,
		// Waiting for the host, PLL held in reset
		boot_hold,
		// Normal running, not reconfiguring
		idle,
		// In reconfiguration mode, waiting for a command
		ready,
		// CLKREG1 write pending, CLKREG2 next
		outdiv_reg2,
		// Last write pending, then command done
		cmd_finish
	} reconfig_state_t;

endpackage

// ==== tb_drp_model.sv ====
module tb_drp_model (
	input logic reconfig_clk,
	input logic reset,

	// DRP slave side
	input logic drp_en,
	input logic drp_we,
	input drp_pkg::drp_addr_t drp_daddr,
	input drp_pkg::drp_data_t drp_din,
	output drp_pkg::drp_data_t drp_dout,
	output logic drp_ready,

	// Cycles from drp_en to drp_ready for the next access, 1 to 4
	input logic [2:0] ready_latency,
	// Register contents loaded while reset is high
	input drp_pkg::drp_data_t init_mem [128],
	// Command done from the DUT, timed against the last write
	input logic reconfig_cmd_done,
	output logic protocol_error
);
	timeunit 1ns;
	timeprecision 1ps;

	drp_pkg::drp_data_t mem [128];
	drp_pkg::drp_data_t dout_q = '0;
	logic ready_q = 1'b0;
	logic pending = 1'b0;
	logic pend_we;
	drp_pkg::drp_addr_t pend_addr;
	drp_pkg::drp_data_t pend_din;
	drp_pkg::drp_addr_t read_addr;
	logic [2:0] wait_cnt;
	// High in the cycle a write is acknowledged
	logic ack_write = 1'b0;
	// Write acks of the last two cycles, bit 1 is the older one
	logic [1:0] ack_hist = 2'b00;
	logic error_flag = 1'b0;

	assign drp_dout = dout_q;
	assign drp_ready = ready_q;
	assign protocol_error = error_flag;

	//////////////////////////////////////////////////
	// Register file with variable ready latency

	always @(posedge reconfig_clk) begin
		ready_q <= 1'b0;
		ack_write <= 1'b0;
		ack_hist <= {ack_hist[0], ack_write};
		if (reset) begin
			pending <= 1'b0;
			dout_q <= '0;
			for (int i = 0; i < 128; i++)
				mem[7'(i)] <= init_mem[7'(i)];
		end else if (drp_en) begin
			// Accept the access and start counting down
			pending <= 1'b1;
			pend_we <= drp_we;
			pend_addr <= drp_daddr;
			pend_din <= drp_din;
			wait_cnt <= ready_latency;
			if (!drp_we)
				read_addr <= drp_daddr;
		end else if (pending) begin
			if (wait_cnt <= 3'd1) begin
				ready_q <= 1'b1;
				ack_write <= pend_we;
				pending <= 1'b0;
				if (pend_we)
					mem[pend_addr] <= pend_din;
				else
					dout_q <= mem[pend_addr];
			end else begin
				wait_cnt <= wait_cnt - 3'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Protocol checks

	always @(posedge reconfig_clk) begin
		if (!reset) begin
			// One access at a time
			if (drp_en) begin
				assert (!pending) else begin
					$display("[ERROR] drp_overlap: expected pending 0, actual %0d", pending);
					error_flag <= 1'b1;
				end
			end
			// Write goes back to the register just read
			if (drp_en && drp_we) begin
				assert (drp_daddr == read_addr) else begin
					$display("[ERROR] drp_write_addr: expected 0x%0h, actual 0x%0h",
						read_addr, drp_daddr);
					error_flag <= 1'b1;
				end
			end
			// Done comes two cycles after the write's ready
			if (reconfig_cmd_done) begin
				assert (ack_hist[1]) else begin
					$display("[ERROR] cmd_done_timing: expected write ready 1, actual %0d",
						ack_hist[1]);
					error_flag <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== tb_pll_reconfig_top.sv ====
module tb_pll_reconfig_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int NUM_COMMANDS = 8;

	// Host side
	logic reconfig_clk = 1'b0;
	logic reset = 1'b1;
	logic pll_reset_req = 1'b0;
	logic reconfig_start = 1'b0;
	logic reconfig_finish = 1'b0;
	logic reconfig_output_en = 1'b0;
	reconfig_pkg::out_idx_t reconfig_output_idx = '0;
	reconfig_pkg::out_div_t reconfig_output_div = 8'd1;
	reconfig_pkg::out_phase_t reconfig_output_phase = '0;
	logic busy;
	logic reconfig_cmd_done;
	logic pll_reset;

	// DRP between DUT and model
	logic drp_en;
	logic drp_we;
	drp_pkg::drp_addr_t drp_daddr;
	drp_pkg::drp_data_t drp_din;
	drp_pkg::drp_data_t drp_dout;
	logic drp_ready;
	logic protocol_error;
	logic [2:0] ready_latency = 3'd1;

	// Separate streams for commands and for ready latency
	logic [31:0] cmd_seed = 32'h3138;
	logic [31:0] latency_seed = 32'h3138;
	// Expected model contents
	drp_pkg::drp_data_t shadow [128];

	always #20 reconfig_clk = ~reconfig_clk;

	pll_reconfig_top UUT (
		.reconfig_clk(reconfig_clk),
		.reset(reset),
		.pll_reset_req(pll_reset_req),
		.reconfig_start(reconfig_start),
		.reconfig_finish(reconfig_finish),
		.reconfig_output_en(reconfig_output_en),
		.reconfig_output_idx(reconfig_output_idx),
		.reconfig_output_div(reconfig_output_div),
		.reconfig_output_phase(reconfig_output_phase),
		.busy(busy),
		.reconfig_cmd_done(reconfig_cmd_done),
		.pll_reset(pll_reset),
		.drp_en(drp_en),
		.drp_we(drp_we),
		.drp_daddr(drp_daddr),
		.drp_din(drp_din),
		.drp_dout(drp_dout),
		.drp_ready(drp_ready)
	);

	tb_drp_model drp_model (
		.reconfig_clk(reconfig_clk),
		.reset(reset),
		.drp_en(drp_en),
		.drp_we(drp_we),
		.drp_daddr(drp_daddr),
		.drp_din(drp_din),
		.drp_dout(drp_dout),
		.drp_ready(drp_ready),
		.ready_latency(ready_latency),
		.init_mem(shadow),
		.reconfig_cmd_done(reconfig_cmd_done),
		.protocol_error(protocol_error)
	);

	//////////////////////////////////////////////////
	// Random numbers

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int rand_below(input int limit);
		cmd_seed = lcg_next(cmd_seed);
		return int'(cmd_seed[31:16]) % limit;
	endfunction

	// New latency of 1 to 4 cycles on every clock
	always @(posedge reconfig_clk) begin
		latency_seed <= lcg_next(latency_seed);
		ready_latency <= 3'(latency_seed[17:16]) + 3'd1;
	end

	//////////////////////////////////////////////////
	// Checking

	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_equal(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual == expected) else begin
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
			stop_with_failure();
		end
	endtask

	// Model flags are seen half a cycle after they are raised
	always @(negedge reconfig_clk) begin
		assert (!protocol_error) else begin
			$display("The DRP model saw a protocol violation");
			stop_with_failure();
		end
	end

	// Outputs are sampled on the falling edge
	task automatic wait_busy_low();
		for (int n = 0; n < TIMEOUT_CYCLES; n++) begin
			@(negedge reconfig_clk);
			if (!busy)
				return;
		end
		$display("Timed out waiting for busy to fall after reset");
		stop_with_failure();
	endtask

	task automatic wait_pll_reset(input logic level, input int max_cycles);
		for (int n = 0; n < max_cycles; n++) begin
			@(negedge reconfig_clk);
			if (pll_reset == level)
				return;
		end
		$display("pll_reset did not reach %0d within %0d cycles", level, max_cycles);
		stop_with_failure();
	endtask

	// PLL must stay in reset for the whole command
	task automatic wait_cmd_done();
		for (int n = 0; n < TIMEOUT_CYCLES; n++) begin
			@(negedge reconfig_clk);
			check_equal("mode_pll_reset", 1, 32'(pll_reset));
			if (reconfig_cmd_done)
				return;
		end
		$display("Timed out waiting for reconfig_cmd_done");
		stop_with_failure();
	endtask

	//////////////////////////////////////////////////
	// Output commands

	function automatic drp_pkg::drp_addr_t clkreg1_addr(input reconfig_pkg::out_idx_t idx);
		case (idx)
			3'd0: return drp_pkg::REG_CLKOUT0_CLKREG1;
			3'd1: return drp_pkg::REG_CLKOUT1_CLKREG1;
			3'd2: return drp_pkg::REG_CLKOUT2_CLKREG1;
			3'd3: return drp_pkg::REG_CLKOUT3_CLKREG1;
			3'd4: return drp_pkg::REG_CLKOUT4_CLKREG1;
			default: return drp_pkg::REG_CLKOUT5_CLKREG1;
		endcase
	endfunction

	task automatic run_command();
		reconfig_pkg::out_idx_t idx;
		reconfig_pkg::out_div_t div;
		reconfig_pkg::out_phase_t phase;
		drp_pkg::drp_addr_t addr1;
		drp_pkg::drp_data_t new1;
		drp_pkg::drp_data_t new2;
		drp_pkg::drp_data_t mask2;
		drp_pkg::drp_data_t exp1;
		drp_pkg::drp_data_t exp2;
		int done_cycles;

		idx = 3'(rand_below(reconfig_pkg::NUM_OUTPUTS));
		div = 8'(rand_below(127) + 1);
		phase = 9'(rand_below(512));
		@(posedge reconfig_clk);
		reconfig_output_idx <= idx;
		reconfig_output_div <= div;
		reconfig_output_phase <= phase;
		reconfig_output_en <= 1'b1;
		@(posedge reconfig_clk);
		reconfig_output_en <= 1'b0;
		wait_cmd_done();

		// Done is a single pulse, PLL still held in reset
		done_cycles = 1;
		repeat (4) begin
			@(negedge reconfig_clk);
			check_equal("mode_pll_reset", 1, 32'(pll_reset));
			if (reconfig_cmd_done)
				done_cycles++;
		end
		check_equal("cmd_done_width", 1, done_cycles);

		// Fine phase, high time, low time with the odd cycle
		new1 = (16'(phase[2:0]) << 13) | (16'(div[6:1]) << 6)
			| 16'(div[6:1] + 6'(div[0]));
		// Edge bit, bypass for divide by 1, coarse phase
		new2 = (16'(div[0]) << 7) | (16'(div == 8'd1) << 6) | 16'(phase[8:3]);
		if (idx == 3'd0)
			mask2 = drp_pkg::MASK_CLKREG2_OUT0;
		else if (idx == 3'd5)
			mask2 = drp_pkg::MASK_CLKREG2_OUT5;
		else
			mask2 = drp_pkg::MASK_CLKREG2_MID;

		addr1 = clkreg1_addr(idx);
		exp1 = (shadow[addr1] & drp_pkg::MASK_CLKREG1) | (new1 & ~drp_pkg::MASK_CLKREG1);
		exp2 = (shadow[addr1 + 7'd1] & mask2) | (new2 & ~mask2);
		shadow[addr1] = exp1;
		shadow[addr1 + 7'd1] = exp2;
		check_equal("clkreg1", 32'(exp1), 32'(drp_model.mem[addr1]));
		check_equal("clkreg2", 32'(exp2), 32'(drp_model.mem[addr1 + 7'd1]));
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		int high_cycles;

		// Model contents are random at reset
		for (int i = 0; i < 128; i++)
			shadow[7'(i)] = 16'(rand_below(65536));

		repeat (2) @(posedge reconfig_clk);
		reset <= 1'b0;

		// Boot
		@(negedge reconfig_clk);
		check_equal("boot_busy", 1, 32'(busy));
		check_equal("boot_pll_reset", 1, 32'(pll_reset));
		check_equal("boot_cmd_done", 0, 32'(reconfig_cmd_done));
		check_equal("boot_drp_en", 0, 32'(drp_en));
		wait_busy_low();
		check_equal("boot_power_reg", 32'h0000ffff,
			32'(drp_model.mem[drp_pkg::REG_POWER_CONFIG]));
		shadow[drp_pkg::REG_POWER_CONFIG] = drp_pkg::POWER_ALL_ON;
		check_equal("hold_pll_reset", 1, 32'(pll_reset));

		// Request in boot hold releases the PLL
		@(posedge reconfig_clk);
		pll_reset_req <= 1'b1;
		@(posedge reconfig_clk);
		pll_reset_req <= 1'b0;
		wait_pll_reset(1'b0, TIMEOUT_CYCLES);

		// Request in idle gives a one-cycle pulse
		@(posedge reconfig_clk);
		pll_reset_req <= 1'b1;
		@(posedge reconfig_clk);
		pll_reset_req <= 1'b0;
		high_cycles = 0;
		repeat (6) begin
			@(negedge reconfig_clk);
			if (pll_reset)
				high_cycles++;
		end
		check_equal("idle_reset_pulse", 1, high_cycles);

		// Reconfiguration mode
		@(posedge reconfig_clk);
		reconfig_start <= 1'b1;
		@(posedge reconfig_clk);
		reconfig_start <= 1'b0;
		wait_pll_reset(1'b1, TIMEOUT_CYCLES);
		for (int n = 0; n < NUM_COMMANDS; n++)
			run_command();

		// PLL leaves reset within two cycles of the finish strobe
		@(posedge reconfig_clk);
		reconfig_finish <= 1'b1;
		@(posedge reconfig_clk);
		reconfig_finish <= 1'b0;
		wait_pll_reset(1'b0, 2);

		$display("PASS: all tests");
		$finish;
	end

endmodule
